//--- rtl/archPkg.sv
// Architecture constants
package archPkg;

  // Data word width
  localparam int xlen = 32;

  // Privilege mode encodings
  localparam logic [1:0] modeM = 2'd3;
  localparam logic [1:0] modeU = 2'd0;

  //////////////////////////////
  // Exception cause codes
  //////////////////////////////
  localparam logic [xlen-1:0] causeInstrMisaligned = 32'd0;
  localparam logic [xlen-1:0] causeInstrAccess     = 32'd1;
  localparam logic [xlen-1:0] causeIllegalInstr    = 32'd2;
  localparam logic [xlen-1:0] causeBreakpoint      = 32'd3;
  localparam logic [xlen-1:0] causeEcallU          = 32'd8;
  localparam logic [xlen-1:0] causeEcallM          = 32'd11;
  localparam logic [xlen-1:0] causeInstrPageFault  = 32'd12;
  localparam logic [xlen-1:0] causeLoadPageFault   = 32'd13;
  localparam logic [xlen-1:0] causeStorePageFault  = 32'd15;

  //////////////////////////////
  // Interrupt cause codes
  //////////////////////////////
  // Also the bit positions in mie and mip
  localparam logic [xlen-1:0] causeMSoftInt  = 32'd3;
  localparam logic [xlen-1:0] causeMTimerInt = 32'd7;
  localparam logic [xlen-1:0] causeMExtInt   = 32'd11;

endpackage

//--- rtl/csrPkg.sv
// Machine CSR definitions
package csrPkg;

  //////////////////////////////
  // CSR addresses
  //////////////////////////////
  localparam logic [11:0] csrMstatus  = 12'h300;
  localparam logic [11:0] csrMie      = 12'h304;
  localparam logic [11:0] csrMtvec    = 12'h305;
  localparam logic [11:0] csrMscratch = 12'h340;
  localparam logic [11:0] csrMepc     = 12'h341;
  localparam logic [11:0] csrMcause   = 12'h342;
  localparam logic [11:0] csrMtval    = 12'h343;
  localparam logic [11:0] csrMip      = 12'h344;

  // mstatus field positions
  localparam int statusMie  = 3;
  localparam int statusMpie = 7;
  // Low bit of the two-bit MPP field
  localparam int statusMpp  = 11;

  //////////////////////////////
  // System instruction codes
  //////////////////////////////
  // Bits 31:20 of the SYSTEM opcode
  localparam logic [11:0] funct12Ecall  = 12'h000;
  localparam logic [11:0] funct12Ebreak = 12'h001;
  localparam logic [11:0] funct12Mret   = 12'h302;
  localparam logic [11:0] funct12Wfi    = 12'h105;

  // Instruction bits 31:20
  // CSR instructions see an address
  // SYSTEM instructions see funct7 and rs2
  typedef union packed {
    logic [11:0] csrAddr;
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
    } sys;
  } sysField_u;

endpackage

//--- rtl/privDecode.sv
`timescale 1ns/1ns
// Privileged instruction decoder
module privDecode (
  input  csrPkg::sysField_u InstrM,
  input  logic              PrivilegedM,
  input  logic              CSRReadM,
  input  logic              CSRWriteM,
  input  logic [1:0]        PrivilegeModeW,
  output logic              ecallM,
  output logic              ebreakM,
  output logic              mretM,
  output logic              wfiM,
  output logic              IllegalCSRAccessM
);
  import archPkg::*;
  import csrPkg::*;

  logic [11:0] funct12;
  logic        userMode;
  logic        csrAccess;
  logic        csrKnown;

  // Rebuild funct12 from the system view
  assign funct12 = {InstrM.sys.funct7, InstrM.sys.rs2};

  assign ecallM  = PrivilegedM && (funct12 == funct12Ecall);
  assign ebreakM = PrivilegedM && (funct12 == funct12Ebreak);
  assign mretM   = PrivilegedM && (funct12 == funct12Mret);
  assign wfiM    = PrivilegedM && (funct12 == funct12Wfi);

  assign userMode  = (PrivilegeModeW == modeU);
  assign csrAccess = CSRReadM || CSRWriteM;

  // Implemented machine CSRs
  always_comb begin
    case (InstrM.csrAddr)
      csrMstatus, csrMie, csrMtvec, csrMscratch,
      csrMepc, csrMcause, csrMtval, csrMip: csrKnown = 1'b1;
      default:                              csrKnown = 1'b0;
    endcase
  end

  // Every CSR is machine level, so U mode may touch none
  // mret from U mode is illegal too
  assign IllegalCSRAccessM = (csrAccess && (userMode || !csrKnown)) ||
                             (mretM && userMode);

  // Trap unit assumes at most one system event per instruction
  always_comb begin
    oneSysEvent: assert final ($onehot0({ecallM, ebreakM, mretM}))
      else $error("More than one system instruction decoded");
  end

endmodule

//--- rtl/faultPipeline.sv
`timescale 1ns/1ns
// Instruction fault pipeline
module faultPipeline (
  input  logic clk,
  input  logic rstN,
  input  logic StallD,
  input  logic StallE,
  input  logic StallM,
  input  logic FlushD,
  input  logic FlushE,
  input  logic FlushM,
  input  logic InstrPageFaultF,
  input  logic InstrAccessFaultF,
  input  logic IllegalInstrFaultD,
  output logic InstrPageFaultM,
  output logic InstrAccessFaultM,
  output logic IllegalInstrFaultM
);

  // D holds {page, access}
  // E and M hold {illegal, page, access}
  logic [1:0] faultD;
  logic [2:0] faultE;
  logic [2:0] faultM;

  // Flush clears a stage even when it is stalled
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      faultD <= '0;
      faultE <= '0;
      faultM <= '0;
    end else begin
      if (FlushD)       faultD <= '0;
      else if (!StallD) faultD <= {InstrPageFaultF, InstrAccessFaultF};

      // Decode illegal flag joins here
      if (FlushE)       faultE <= '0;
      else if (!StallE) faultE <= {IllegalInstrFaultD, faultD};

      if (FlushM)       faultM <= '0;
      else if (!StallM) faultM <= faultE;
    end
  end

  assign {IllegalInstrFaultM, InstrPageFaultM, InstrAccessFaultM} = faultM;

endmodule

//--- rtl/csrArbiter.sv
`timescale 1ns/1ns
// CSR write port arbiter
module csrArbiter (
  input  logic trapWrite,
  input  logic CSRWriteM,
  input  logic IllegalCSRAccessM,
  output logic grantTrap,
  output logic grantInstr
);

  // Trap unit has fixed priority
  assign grantTrap = trapWrite;

  // Instruction write only when legal and the port is free
  // A refused write is dropped since its instruction is squashed
  assign grantInstr = CSRWriteM && !IllegalCSRAccessM && !trapWrite;

  // Single write port
  always_comb begin
    grantOneHot: assert final (!(grantTrap && grantInstr))
      else $error("CSR write port granted to both requesters");
  end

endmodule

//--- rtl/csrFile.sv
`timescale 1ns/1ns
// Machine CSR file
module csrFile (
  input  logic                     clk,
  input  logic                     rstN,
  input  logic                     StallW,
  input  logic                     CSRReadM,
  input  logic                     grantInstr,
  input  logic                     grantTrap,
  input  csrPkg::sysField_u        InstrM,
  input  logic [1:0]               csrOp,
  input  logic [archPkg::xlen-1:0] SrcAM,
  input  logic [archPkg::xlen-1:0] trapMepc,
  input  logic [archPkg::xlen-1:0] trapMcause,
  input  logic [archPkg::xlen-1:0] trapMtval,
  input  logic [archPkg::xlen-1:0] trapMstatus,
  input  logic                     TimerIntM,
  input  logic                     ExtIntM,
  input  logic                     SwIntM,
  output logic [archPkg::xlen-1:0] CSRReadValW,
  output logic [archPkg::xlen-1:0] MTVEC_REGW,
  output logic [archPkg::xlen-1:0] MEPC_REGW,
  output logic [archPkg::xlen-1:0] MSTATUS_REGW,
  output logic [archPkg::xlen-1:0] MIE_REGW,
  output logic [archPkg::xlen-1:0] MIP_REGW
);
  import archPkg::*;
  import csrPkg::*;

  logic [xlen-1:0] mscratch;
  logic [xlen-1:0] mcause;
  logic [xlen-1:0] mtval;
  logic [xlen-1:0] readValM;
  logic [xlen-1:0] writeVal;
  logic [xlen-1:0] statusWr;
  logic [xlen-1:0] mieWr;
  logic [xlen-1:0] mipNext;
  logic [1:0]      mppWr;
  logic            instrEn;
  logic            trapEn;

  // No update while writeback is stalled
  assign instrEn = grantInstr && !StallW;
  assign trapEn  = grantTrap && !StallW;

  //////////////////////////////
  // Read mux
  //////////////////////////////
  always_comb begin
    case (InstrM.csrAddr)
      csrMstatus:  readValM = MSTATUS_REGW;
      csrMie:      readValM = MIE_REGW;
      csrMtvec:    readValM = MTVEC_REGW;
      csrMscratch: readValM = mscratch;
      csrMepc:     readValM = MEPC_REGW;
      csrMcause:   readValM = mcause;
      csrMtval:    readValM = mtval;
      csrMip:      readValM = MIP_REGW;
      default:     readValM = '0;
    endcase
  end

  // csrOp follows funct3[1:0] of csrrw, csrrs and csrrc
  always_comb begin
    case (csrOp)
      2'b10:   writeVal = readValM | SrcAM;
      2'b11:   writeVal = readValM & ~SrcAM;
      default: writeVal = SrcAM;
    endcase
  end

  // mstatus keeps only MIE, MPIE and MPP
  // Reserved MPP values 1 and 2 leave the field unchanged
  assign mppWr = writeVal[statusMpp +: 2];
  always_comb begin
    statusWr = '0;
    statusWr[statusMie]  = writeVal[statusMie];
    statusWr[statusMpie] = writeVal[statusMpie];
    if ((mppWr == modeM) || (mppWr == modeU)) statusWr[statusMpp +: 2] = mppWr;
    else statusWr[statusMpp +: 2] = MSTATUS_REGW[statusMpp +: 2];
  end

  // Only the three machine interrupt enables exist
  always_comb begin
    mieWr = '0;
    mieWr[causeMSoftInt]  = writeVal[causeMSoftInt];
    mieWr[causeMTimerInt] = writeVal[causeMTimerInt];
    mieWr[causeMExtInt]   = writeVal[causeMExtInt];
    mipNext = '0;
    mipNext[causeMSoftInt]  = SwIntM;
    mipNext[causeMTimerInt] = TimerIntM;
    mipNext[causeMExtInt]   = ExtIntM;
  end

  //////////////////////////////
  // Control registers
  //////////////////////////////
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      MSTATUS_REGW <= '0;
      MIE_REGW     <= '0;
      MIP_REGW     <= '0;
      CSRReadValW  <= '0;
    end else begin
      // mip just samples the lines
      MIP_REGW <= mipNext;
      // Read value is the one before this cycle's write
      if (!StallW) CSRReadValW <= CSRReadM ? readValM : '0;
      if (trapEn) MSTATUS_REGW <= trapMstatus;
      else if (instrEn && (InstrM.csrAddr == csrMstatus)) MSTATUS_REGW <= statusWr;
      if (instrEn && (InstrM.csrAddr == csrMie)) MIE_REGW <= mieWr;
    end
  end

  // Payload registers
  always_ff @(posedge clk) begin
    if (trapEn) begin
      MEPC_REGW <= {trapMepc[xlen-1:2], 2'b00};
      mcause    <= trapMcause;
      mtval     <= trapMtval;
    end else if (instrEn) begin
      case (InstrM.csrAddr)
        csrMtvec:    MTVEC_REGW <= {writeVal[xlen-1:2], 1'b0, writeVal[0]};  // Mode 0 or 1
        csrMepc:     MEPC_REGW  <= {writeVal[xlen-1:2], 2'b00};
        csrMscratch: mscratch   <= writeVal;
        csrMcause:   mcause     <= writeVal;
        csrMtval:    mtval      <= writeVal;
        default:     ;
      endcase
    end
  end

  // Arbiter and trap unit must never both land a write
  grantsApart: assert property (@(posedge clk) disable iff (!rstN)
                                !(grantTrap && grantInstr))
    else $error("Trap and instruction CSR writes in the same cycle");

endmodule

//--- rtl/trapUnit.sv
`timescale 1ns/1ns
// Trap and return control
module trapUnit (
  input  logic                     clk,
  input  logic                     rstN,
  input  logic                     StallW,
  input  logic [archPkg::xlen-1:0] PCM,
  input  logic [archPkg::xlen-1:0] InstrMisalignedAdrM,
  input  logic [archPkg::xlen-1:0] MemAdrM,
  input  logic                     InstrMisalignedFaultM,
  input  logic                     LoadPageFaultM,
  input  logic                     StorePageFaultM,
  input  logic                     InstrPageFaultM,
  input  logic                     InstrAccessFaultM,
  input  logic                     IllegalInstrFaultM,
  input  logic                     ecallM,
  input  logic                     ebreakM,
  input  logic                     mretM,
  input  logic                     IllegalCSRAccessM,
  input  logic [archPkg::xlen-1:0] MTVEC_REGW,
  input  logic [archPkg::xlen-1:0] MEPC_REGW,
  input  logic [archPkg::xlen-1:0] MSTATUS_REGW,
  input  logic [archPkg::xlen-1:0] MIE_REGW,
  input  logic [archPkg::xlen-1:0] MIP_REGW,
  output logic                     TrapM,
  output logic                     RetM,
  output logic [archPkg::xlen-1:0] PrivilegedNextPCM,
  output logic [1:0]               PrivilegeModeW,
  output logic                     trapWrite,
  output logic [archPkg::xlen-1:0] trapMepc,
  output logic [archPkg::xlen-1:0] trapMcause,
  output logic [archPkg::xlen-1:0] trapMtval,
  output logic [archPkg::xlen-1:0] trapMstatus
);
  import archPkg::*;
  import csrPkg::*;

  logic [xlen-1:0] pendingInt;
  logic [xlen-1:0] causeM;
  logic [xlen-1:0] tvalM;
  logic [xlen-1:0] trapBase;
  logic [xlen-1:0] statusTrap;
  logic [xlen-1:0] statusRet;
  logic [1:0]      nextModeM;
  logic            intEnable;
  logic            interruptM;

  // Interrupts are always enabled below M mode
  assign pendingInt = MIP_REGW & MIE_REGW;
  assign intEnable  = MSTATUS_REGW[statusMie] || (PrivilegeModeW == modeU);

  //////////////////////////////
  // Trap priority
  //////////////////////////////
  always_comb begin
    TrapM      = 1'b1;
    interruptM = 1'b0;
    causeM     = '0;
    tvalM      = '0;
    if (intEnable && pendingInt[causeMExtInt]) begin
      interruptM = 1'b1;
      causeM     = {1'b1, causeMExtInt[xlen-2:0]};
    end else if (intEnable && pendingInt[causeMSoftInt]) begin
      interruptM = 1'b1;
      causeM     = {1'b1, causeMSoftInt[xlen-2:0]};
    end else if (intEnable && pendingInt[causeMTimerInt]) begin
      interruptM = 1'b1;
      causeM     = {1'b1, causeMTimerInt[xlen-2:0]};
    end else if (InstrPageFaultM) begin
      causeM = causeInstrPageFault;
      tvalM  = PCM;
    end else if (InstrAccessFaultM) begin
      causeM = causeInstrAccess;
    end else if (IllegalInstrFaultM || IllegalCSRAccessM) begin
      causeM = causeIllegalInstr;
    end else if (InstrMisalignedFaultM) begin
      causeM = causeInstrMisaligned;
      tvalM  = InstrMisalignedAdrM;
    end else if (ebreakM) begin
      causeM = causeBreakpoint;
    end else if (ecallM) begin
      causeM = (PrivilegeModeW == modeU) ? causeEcallU : causeEcallM;
    end else if (StorePageFaultM) begin
      causeM = causeStorePageFault;
      tvalM  = MemAdrM;
    end else if (LoadPageFaultM) begin
      causeM = causeLoadPageFault;
      tvalM  = MemAdrM;
    end else begin
      TrapM = 1'b0;
    end
  end

  // A trapping mret does not return
  assign RetM = mretM && !TrapM;

  // Vectored mode offsets interrupts by four times the cause
  assign trapBase = {MTVEC_REGW[xlen-1:2], 2'b00};
  always_comb begin
    if (!TrapM) PrivilegedNextPCM = MEPC_REGW;
    else if (interruptM && MTVEC_REGW[0]) PrivilegedNextPCM = trapBase + {causeM[xlen-3:0], 2'b00};
    else PrivilegedNextPCM = trapBase;
  end

  // mstatus stack push on trap, pop on mret
  always_comb begin
    statusTrap = MSTATUS_REGW;
    statusTrap[statusMpie]       = MSTATUS_REGW[statusMie];
    statusTrap[statusMie]        = 1'b0;
    statusTrap[statusMpp +: 2]   = PrivilegeModeW;
    statusRet = MSTATUS_REGW;
    statusRet[statusMie]         = MSTATUS_REGW[statusMpie];
    statusRet[statusMpie]        = 1'b1;
    statusRet[statusMpp +: 2]    = modeU;
  end

  // mret rewrites mepc unchanged and clears mcause and mtval
  assign trapWrite   = (TrapM || RetM) && !StallW;
  assign trapMstatus = TrapM ? statusTrap : statusRet;
  assign trapMepc    = TrapM ? PCM : MEPC_REGW;
  assign trapMcause  = causeM;
  assign trapMtval   = tvalM;

  //////////////////////////////
  // Privilege mode
  //////////////////////////////
  always_comb begin
    if (TrapM)     nextModeM = modeM;
    else if (RetM) nextModeM = MSTATUS_REGW[statusMpp +: 2];
    else           nextModeM = PrivilegeModeW;
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN)        PrivilegeModeW <= modeM;
    else if (!StallW) PrivilegeModeW <= nextModeM;
  end

  // Trap write through the arbiter must mask interrupts
  trapMasksInts: assert property (@(posedge clk) disable iff (!rstN)
                                  TrapM && !StallW |=> !MSTATUS_REGW[statusMie])
    else $error("mstatus.MIE still set after a trap");

endmodule

//--- rtl/privileged.sv
`timescale 1ns/1ns
// Machine mode privileged unit
module privileged (
  input  logic                     clk,
  input  logic                     rstN,
  input  logic                     StallD,
  input  logic                     StallE,
  input  logic                     StallM,
  input  logic                     StallW,
  input  logic                     FlushD,
  input  logic                     FlushE,
  input  logic                     FlushM,
  input  csrPkg::sysField_u        InstrM,
  input  logic                     PrivilegedM,
  input  logic                     CSRReadM,
  input  logic                     CSRWriteM,
  input  logic [1:0]               csrOp,
  input  logic [archPkg::xlen-1:0] SrcAM,
  input  logic [archPkg::xlen-1:0] PCM,
  input  logic [archPkg::xlen-1:0] InstrMisalignedAdrM,
  input  logic [archPkg::xlen-1:0] MemAdrM,
  input  logic                     InstrPageFaultF,
  input  logic                     InstrAccessFaultF,
  input  logic                     IllegalInstrFaultD,
  input  logic                     InstrMisalignedFaultM,
  input  logic                     LoadPageFaultM,
  input  logic                     StorePageFaultM,
  input  logic                     TimerIntM,
  input  logic                     ExtIntM,
  input  logic                     SwIntM,
  output logic [archPkg::xlen-1:0] CSRReadValW,
  output logic [archPkg::xlen-1:0] PrivilegedNextPCM,
  output logic                     TrapM,
  output logic                     RetM,
  output logic                     wfiM,
  output logic [1:0]               PrivilegeModeW
);
  import archPkg::*;

  // Decoder outputs
  logic ecallM;
  logic ebreakM;
  logic mretM;
  logic IllegalCSRAccessM;

  // Faults reaching M
  logic InstrPageFaultM;
  logic InstrAccessFaultM;
  logic IllegalInstrFaultM;

  // Shared write port
  logic            trapWrite;
  logic            grantTrap;
  logic            grantInstr;
  logic [xlen-1:0] trapMepc;
  logic [xlen-1:0] trapMcause;
  logic [xlen-1:0] trapMtval;
  logic [xlen-1:0] trapMstatus;

  // CSR state seen by the trap unit
  logic [xlen-1:0] MTVEC_REGW;
  logic [xlen-1:0] MEPC_REGW;
  logic [xlen-1:0] MSTATUS_REGW;
  logic [xlen-1:0] MIE_REGW;
  logic [xlen-1:0] MIP_REGW;

  //////////////////////////////
  // Submodules
  //////////////////////////////
  privDecode    decode  (.*);
  faultPipeline faults  (.*);
  csrArbiter    arbiter (.*);
  csrFile       csrs    (.*);
  trapUnit      trap    (.*);

endmodule

//--- tests/privilegedTb.sv
`timescale 1ns/1ns
// Privileged unit testbench
module privilegedTb;
  import archPkg::*;
  import csrPkg::*;

  // Per-test cycle budgets including reset
  localparam int testCycles = 5 + 40 + 15 + 25 + 35 + 35 + 30;
  localparam int timeoutCycles = 2 * testCycles;

  logic clk;
  logic rstN;
  logic StallD, StallE, StallM, StallW;
  logic FlushD, FlushE, FlushM;
  sysField_u InstrM;
  logic PrivilegedM, CSRReadM, CSRWriteM;
  logic [1:0] csrOp;
  logic [xlen-1:0] SrcAM, PCM, InstrMisalignedAdrM, MemAdrM;
  logic InstrPageFaultF, InstrAccessFaultF, IllegalInstrFaultD;
  logic InstrMisalignedFaultM, LoadPageFaultM, StorePageFaultM;
  logic TimerIntM, ExtIntM, SwIntM;
  logic [xlen-1:0] CSRReadValW, PrivilegedNextPCM;
  logic TrapM, RetM, wfiM;
  logic [1:0] PrivilegeModeW;

  // Reference model state
  logic [xlen-1:0] mStatus, mIe, mIp, mTvec, mEpc, mScratch, mCause, mTval;
  logic [xlen-1:0] expRead;
  logic [1:0] mMode;
  logic [1:0] fD;
  logic [2:0] fE, fM;

  logic [31:0] lfsrState;
  int checks;
  int errors;
  int testErrs;
  int cycles;

  privileged u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  //////////////////////////////
  // Random source
  //////////////////////////////
  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  // One LFSR step per bit
  task automatic randWord(output logic [xlen-1:0] w);
    for (int i = 0; i < xlen; i++) begin
      w[i] = lfsrState[0];
      lfsrState = lfsrNext(lfsrState);
    end
  endtask

  //////////////////////////////
  // Compare tasks
  //////////////////////////////
  task automatic checkWord(input string what, input logic [xlen-1:0] got, exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic checkMode(input string what, input logic [1:0] got, exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic checkFlag(input string what, input logic got, exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  //////////////////////////////
  // Reference model
  //////////////////////////////
  function automatic logic csrKnownRef(input logic [11:0] a);
    return a inside {csrMstatus, csrMie, csrMtvec, csrMscratch,
                     csrMepc, csrMcause, csrMtval, csrMip};
  endfunction

  function automatic logic [xlen-1:0] csrValueRef(input logic [11:0] a);
    case (a)
      csrMstatus:  return mStatus;
      csrMie:      return mIe;
      csrMtvec:    return mTvec;
      csrMscratch: return mScratch;
      csrMepc:     return mEpc;
      csrMcause:   return mCause;
      csrMtval:    return mTval;
      csrMip:      return mIp;
      default:     return '0;
    endcase
  endfunction

  function automatic logic csrIllegalRef();
    logic mret;
    mret = PrivilegedM && (InstrM.csrAddr == funct12Mret);
    return ((CSRReadM || CSRWriteM) && (mMode == modeU || !csrKnownRef(InstrM.csrAddr))) ||
           (mret && mMode == modeU);
  endfunction

  // Returns {trap, cause, tval, next PC}
  function automatic logic [3*xlen:0] refTrap();
    logic [xlen-1:0] pend, cause, tval, pc;
    logic ie, trap, intr;
    logic [11:0] f12;
    pend = mIp & mIe;
    ie = mStatus[statusMie] || (mMode == modeU);
    f12 = InstrM.csrAddr;
    trap = 1'b1;
    intr = ie && (pend[11] || pend[3] || pend[7]);
    tval = '0;
    if (ie && pend[11]) cause = 32'h8000000b;
    else if (ie && pend[3]) cause = 32'h80000003;
    else if (ie && pend[7]) cause = 32'h80000007;
    else if (fM[1]) begin
      cause = 32'd12;
      tval = PCM;
    end else if (fM[0]) cause = 32'd1;
    else if (fM[2] || csrIllegalRef()) cause = 32'd2;
    else if (InstrMisalignedFaultM) begin
      cause = 32'd0;
      tval = InstrMisalignedAdrM;
    end else if (PrivilegedM && f12 == funct12Ebreak) cause = 32'd3;
    else if (PrivilegedM && f12 == funct12Ecall) cause = (mMode == modeU) ? 32'd8 : 32'd11;
    else if (StorePageFaultM || LoadPageFaultM) begin
      cause = StorePageFaultM ? 32'd15 : 32'd13;
      tval = MemAdrM;
    end else begin
      trap = 1'b0;
      cause = '0;
    end
    pc = mTvec & ~32'd3;
    if (!trap) pc = mEpc;
    else if (intr && mTvec[0]) pc = pc + {cause[xlen-3:0], 2'b00};
    return {trap, cause, tval, pc};
  endfunction

  // Next state of the model at the coming edge
  task automatic updateModel(input logic trap, ret, input logic [xlen-1:0] cause, tval);
    logic [xlen-1:0] old, wv;
    logic [1:0] mode;
    if (trap) begin
      mEpc = PCM & ~32'd3;
      mCause = cause;
      mTval = tval;
      mStatus[7] = mStatus[3];
      mStatus[3] = 1'b0;
      mStatus[12:11] = mMode;
      mMode = modeM;
    end else if (ret) begin
      mode = mStatus[12:11];
      mStatus[3] = mStatus[7];
      mStatus[7] = 1'b1;
      mStatus[12:11] = modeU;
      mMode = mode;
      mCause = '0;
      mTval = '0;
    end else if (CSRWriteM) begin
      old = csrValueRef(InstrM.csrAddr);
      wv = (csrOp == 2'b10) ? (old | SrcAM) : (csrOp == 2'b11) ? (old & ~SrcAM) : SrcAM;
      case (InstrM.csrAddr)
        csrMstatus: begin
          mStatus[3] = wv[3];
          mStatus[7] = wv[7];
          if (wv[12:11] == 2'd0 || wv[12:11] == 2'd3) mStatus[12:11] = wv[12:11];
        end
        csrMie:      mIe = wv & 32'h888;
        csrMtvec:    mTvec = wv & ~32'd2;
        csrMepc:     mEpc = wv & ~32'd3;
        csrMscratch: mScratch = wv;
        csrMcause:   mCause = wv;
        csrMtval:    mTval = wv;
        default:     ;
      endcase
    end
    mIp = {20'd0, ExtIntM, 3'd0, TimerIntM, 3'd0, SwIntM, 3'd0};
    // Fault stages from the oldest
    fM = FlushM ? 3'd0 : StallM ? fM : fE;
    fE = FlushE ? 3'd0 : StallE ? fE : {IllegalInstrFaultD, fD};
    fD = FlushD ? 2'd0 : StallD ? fD : {InstrPageFaultF, InstrAccessFaultF};
  endtask

  // Checks every cycle where the outputs are settled
  always @(negedge clk) begin : compare
    logic [3*xlen:0] r;
    logic ret;
    if (rstN) begin
      r = refTrap();
      ret = PrivilegedM && InstrM.csrAddr == funct12Mret && !r[3*xlen];
      checkFlag("TrapM", TrapM, r[3*xlen]);
      checkFlag("RetM", RetM, ret);
      checkFlag("wfiM", wfiM, PrivilegedM && InstrM.csrAddr == funct12Wfi);
      if (r[3*xlen] || ret) checkWord("PrivilegedNextPCM", PrivilegedNextPCM, r[xlen-1:0]);
      checkMode("PrivilegeModeW", PrivilegeModeW, mMode);
      checkWord("CSRReadValW", CSRReadValW, expRead);
      expRead = CSRReadM ? csrValueRef(InstrM.csrAddr) : '0;
      if (r[3*xlen]) updateModel(1'b1, 1'b0, r[3*xlen-1:2*xlen], r[2*xlen-1:xlen]);
      else updateModel(1'b0, ret, '0, '0);
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > timeoutCycles) begin
      $display("Run did not finish within %0d cycles", timeoutCycles);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  //////////////////////////////
  // Stimulus helpers
  //////////////////////////////
  // Idle strobes
  // A test overrides them after this
  task automatic nextCycle();
    @(posedge clk);
    PrivilegedM <= 1'b0;
    CSRReadM <= 1'b0;
    CSRWriteM <= 1'b0;
    InstrPageFaultF <= 1'b0;
    InstrAccessFaultF <= 1'b0;
    IllegalInstrFaultD <= 1'b0;
    InstrMisalignedFaultM <= 1'b0;
    LoadPageFaultM <= 1'b0;
    StorePageFaultM <= 1'b0;
    {StallD, StallE, StallM, StallW} <= 4'd0;
    {FlushD, FlushE, FlushM} <= 3'd0;
  endtask

  task automatic writeCsr(input logic [11:0] a, input logic [xlen-1:0] v, input logic [1:0] op);
    nextCycle();
    CSRWriteM <= 1'b1;
    InstrM <= a;
    SrcAM <= v;
    csrOp <= op;
  endtask

  task automatic readCsr(input logic [11:0] a, input logic [xlen-1:0] exp);
    nextCycle();
    CSRReadM <= 1'b1;
    InstrM <= a;
    nextCycle();
    @(negedge clk);
    checkWord("CSR read", CSRReadValW, exp);
  endtask

  task automatic sysInstr(input logic [11:0] f12, input logic [xlen-1:0] pc);
    nextCycle();
    PrivilegedM <= 1'b1;
    InstrM <= f12;
    PCM <= pc;
  endtask

  // Counts cycles until TrapM while the first cycles stall the stages
  task automatic waitTrap(input int stalls, input int expDelay);
    int i;
    for (i = 1; i <= 10; i++) begin
      nextCycle();
      if (i <= stalls) {StallD, StallE, StallM} <= 3'b111;
      @(negedge clk);
      if (TrapM) break;
    end
    if (i > 10) begin
      errors++;
      $display("TrapM never rose after the injected fault");
    end else checkWord("trap delay", i, expDelay);
  endtask

  task automatic endTest(input string name);
    $display("%s: %s", name, (errors == testErrs) ? "ok" : "errors");
    testErrs = errors;
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////
  initial begin
    logic [xlen-1:0] r, lastScratch;
    lfsrState = 32'h73f5c6da;
    {checks, errors, testErrs, cycles} = '0;
    {mStatus, mIe, mIp, mTvec, mEpc, mScratch, mCause, mTval, expRead} = '0;
    mMode = modeM;
    {fD, fE, fM} = '0;
    rstN = 1'b0;
    {StallD, StallE, StallM, StallW, FlushD, FlushE, FlushM} = '0;
    {PrivilegedM, CSRReadM, CSRWriteM, csrOp} = '0;
    InstrM = '0;
    {SrcAM, PCM, InstrMisalignedAdrM, MemAdrM} = '0;
    {InstrPageFaultF, InstrAccessFaultF, IllegalInstrFaultD} = '0;
    {InstrMisalignedFaultM, LoadPageFaultM, StorePageFaultM} = '0;
    {TimerIntM, ExtIntM, SwIntM} = '0;
    repeat (5) @(posedge clk);
    rstN <= 1'b1;

    for (int k = 0; k < 3; k++) begin
      randWord(r);
      writeCsr(csrMscratch, r, 2'b01);
      readCsr(csrMscratch, r);
      lastScratch = r;
      randWord(r);
      writeCsr(csrMtvec, r, 2'b01);
      readCsr(csrMtvec, r & ~32'd2);
      randWord(r);
      writeCsr(csrMepc, r, 2'b01);
      readCsr(csrMepc, r & ~32'd3);
    end
    endTest("CSR readback");

    writeCsr(csrMtvec, 32'h100, 2'b01);
    sysInstr(funct12Wfi, 32'h1fc);
    sysInstr(funct12Ecall, 32'h200);
    readCsr(csrMcause, 32'd11);
    readCsr(csrMepc, 32'h200);
    readCsr(csrMstatus, 32'h1800);
    endTest("Ecall in M mode");

    writeCsr(csrMstatus, 32'h1800, 2'b11);
    sysInstr(funct12Mret, 32'h204);
    nextCycle();
    @(negedge clk);
    checkMode("mode after mret", PrivilegeModeW, modeU);
    writeCsr(csrMscratch, 32'hdead, 2'b01);
    readCsr(csrMscratch, lastScratch);
    readCsr(csrMcause, 32'd2);
    endTest("Mret and U mode CSR access");

    writeCsr(csrMtvec, 32'h101, 2'b01);
    writeCsr(csrMie, 32'h80, 2'b01);
    TimerIntM <= 1'b1;
    repeat (2) nextCycle();
    @(negedge clk);
    checkFlag("masked interrupt", TrapM, 1'b0);
    writeCsr(csrMstatus, 32'h8, 2'b10);
    sysInstr(funct12Ecall, 32'h300);
    TimerIntM <= 1'b0;
    @(negedge clk);
    checkWord("vectored PC", PrivilegedNextPCM, 32'h11c);
    writeCsr(csrMstatus, 32'h1880, 2'b11);
    sysInstr(funct12Mret, 32'h304);
    nextCycle();
    TimerIntM <= 1'b1;
    nextCycle();
    TimerIntM <= 1'b0;
    @(negedge clk);
    checkFlag("interrupt in U mode", TrapM, 1'b1);
    endTest("Timer interrupt");

    nextCycle();
    InstrPageFaultF <= 1'b1;
    PCM <= 32'h400;
    waitTrap(0, 3);
    nextCycle();
    InstrPageFaultF <= 1'b1;
    FlushD <= 1'b1;
    repeat (3) nextCycle();
    @(negedge clk);
    checkFlag("flushed fault", TrapM, 1'b0);
    nextCycle();
    InstrPageFaultF <= 1'b1;
    waitTrap(2, 5);
    readCsr(csrMcause, 32'd12);
    endTest("Fault pipeline");

    randWord(r);
    nextCycle();
    LoadPageFaultM <= 1'b1;
    MemAdrM <= r;
    readCsr(csrMcause, 32'd13);
    readCsr(csrMtval, r);
    nextCycle();
    StorePageFaultM <= 1'b1;
    readCsr(csrMcause, 32'd15);
    nextCycle();
    LoadPageFaultM <= 1'b1;
    StorePageFaultM <= 1'b1;
    InstrMisalignedFaultM <= 1'b1;
    InstrMisalignedAdrM <= 32'h602;
    readCsr(csrMcause, 32'd0);
    readCsr(csrMtval, 32'h602);
    endTest("Data page faults");

    nextCycle();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

//--- compile.f
rtl/archPkg.sv
rtl/csrPkg.sv
rtl/privDecode.sv
rtl/faultPipeline.sv
rtl/csrArbiter.sv
rtl/csrFile.sv
rtl/trapUnit.sv
rtl/privileged.sv
tests/privilegedTb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module privilegedTb -f compile.f

output="$(./obj_dir/VprivilegedTb)"
echo "$output"

if grep -qF -- '*** TEST PASSED ***' <<< "$output"; then
  exit 0
else
  exit 1
fi
